// ==== source/divider_pkg.sv ====
// shared widths, data types, quotient digit encoding and latency constants for the SRT divider
package divider_pkg;

    // operand and pipeline geometry
    localparam int word_w      = 32;
    localparam int stage_count = 16;
    localparam int div_latency = stage_count + 1;

    // digit table index widths
    localparam int div_top_w = 3;
    localparam int rem_top_w = 6;

    typedef logic [word_w-1:0]   word_t;
    typedef logic [2*word_w-1:0] dword_t;

    // partial remainder on top, dividend bits below, sign bit at the very top
    typedef logic [2*word_w:0]   partial_t;

    typedef logic [4:0]          shift_t;

    // radix-4 quotient digit
    typedef enum logic [2:0] {
        two_n,
        one_n,
        zero_p,
        one_p,
        two_p,
        digit_invalid
    } qdigit_e;

    // result sign restore, carried with each operation
    typedef struct packed {
        logic neg_quotient;
        logic neg_remainder;
    } sign_fix_t;

    // one pipeline slot
    typedef struct packed {
        logic      valid;
        shift_t    shift;
        word_t     divisor;
        partial_t  partial;
        word_t     quotient;
        sign_fix_t sign;
    } srt_state_t;

endpackage

// ==== source/srt_normalize.sv ====
// leading-one normalizer that left-aligns the divisor and shifts the dividend to match
`timescale 1ns/1ns

module srt_normalize
    import divider_pkg::*;
(
    input  word_t      dividend,
    input  word_t      divisor,
    output srt_state_t state
);

    shift_t shift_amt;

    // highest set bit wins, so scan upward
    always_comb begin
        shift_amt = '0;
        for (int i = 0; i < word_w; i++) begin
            if (divisor[i]) begin
                shift_amt = shift_t'(word_w - 1 - i);
            end
        end
    end

    always_comb begin
        state         = '0;
        state.shift   = shift_amt;
        state.divisor = divisor << shift_amt;
        // dividend zero extended before the shift so no bits are lost
        state.partial = partial_t'(dividend) << shift_amt;
        // a unit divisor with dividend bit 31 set starts above the digit range
        // taking one divisor off leaves the quotient the same mod 2^32
        if (state.partial[2*word_w-2]) begin
            state.partial[2*word_w:word_w] = state.partial[2*word_w:word_w]
                                           - {1'b0, state.divisor};
        end
    end

endmodule

// ==== source/srt_digit_select.sv ====
// radix-4 SRT quotient digit selection from the divisor and partial remainder top bits
`timescale 1ns/1ns

module srt_digit_select
    import divider_pkg::*;
(
    input  logic [div_top_w-1:0] div_top,
    input  logic [rem_top_w-1:0] rem_top,
    output qdigit_e              digit
);

    logic signed [rem_top_w-1:0] rem;

    // per row: low edge of -2, -1, 0, +1, +2 and high edge of +2
    logic signed [rem_top_w-1:0] bound [6];

    assign rem = $signed(rem_top);

    always_comb begin
        case (div_top)
            3'd0: begin
                bound = '{-6'sd12, -6'sd6, -6'sd2, 6'sd2, 6'sd6, 6'sd11};
            end
            3'd1: begin
                bound = '{-6'sd14, -6'sd7, -6'sd2, 6'sd3, 6'sd7, 6'sd13};
            end
            3'd2: begin
                bound = '{-6'sd15, -6'sd8, -6'sd2, 6'sd3, 6'sd8, 6'sd14};
            end
            3'd3: begin
                bound = '{-6'sd16, -6'sd8, -6'sd2, 6'sd3, 6'sd9, 6'sd15};
            end
            // wider divisors get a wider zero band
            3'd4: begin
                bound = '{-6'sd18, -6'sd9, -6'sd3, 6'sd4, 6'sd10, 6'sd17};
            end
            3'd5: begin
                bound = '{-6'sd19, -6'sd10, -6'sd3, 6'sd4, 6'sd10, 6'sd18};
            end
            3'd6: begin
                bound = '{-6'sd20, -6'sd10, -6'sd3, 6'sd4, 6'sd11, 6'sd19};
            end
            3'd7: begin
                bound = '{-6'sd22, -6'sd11, -6'sd3, 6'sd5, 6'sd12, 6'sd21};
            end
        endcase
    end

    // ranges are contiguous within a row
    always_comb begin
        if (rem < bound[0] || rem > bound[5]) begin
            digit = digit_invalid;
        end else if (rem < bound[1]) begin
            digit = two_n;
        end else if (rem < bound[2]) begin
            digit = one_n;
        end else if (rem < bound[3]) begin
            digit = zero_p;
        end else if (rem < bound[4]) begin
            digit = one_p;
        end else begin
            digit = two_p;
        end
    end

endmodule

// ==== source/srt_stage.sv ====
// one radix-4 SRT iteration producing two quotient bits per pipeline stage
`timescale 1ns/1ns

module srt_stage
    import divider_pkg::*;
(
    input  srt_state_t in_state,
    output srt_state_t out_state
);

    qdigit_e        digit;
    partial_t       shifted;
    logic [word_w:0] rem_hi;
    logic [word_w:0] new_hi;
    word_t          q_dec;
    word_t          new_q;

    // bits just below the divisor's leading one, top of the remainder with its sign
    srt_digit_select u_digit (
        .div_top (in_state.divisor[word_w-2 -: div_top_w]),
        .rem_top (in_state.partial[2*word_w -: rem_top_w]),
        .digit   (digit)
    );

    assign shifted = in_state.partial << 2;
    assign rem_hi  = shifted[2*word_w:word_w];
    assign q_dec   = in_state.quotient - 1'b1;

    always_comb begin
        case (digit)
            two_p: begin
                new_hi = rem_hi - {in_state.divisor, 1'b0};
                new_q  = {in_state.quotient[word_w-3:0], 2'b10};
            end
            one_p: begin
                new_hi = rem_hi - {1'b0, in_state.divisor};
                new_q  = {in_state.quotient[word_w-3:0], 2'b01};
            end
            zero_p: begin
                new_hi = rem_hi;
                new_q  = {in_state.quotient[word_w-3:0], 2'b00};
            end
            // negative digits borrow one from the quotient so far
            one_n: begin
                new_hi = rem_hi + {1'b0, in_state.divisor};
                new_q  = {q_dec[word_w-3:0], 2'b11};
            end
            two_n: begin
                new_hi = rem_hi + {in_state.divisor, 1'b0};
                new_q  = {q_dec[word_w-3:0], 2'b10};
            end
            default: begin
                new_hi = '0;
                new_q  = '0;
            end
        endcase
    end

    always_comb begin
        out_state          = in_state;
        out_state.partial  = {new_hi, shifted[word_w-1:0]};
        out_state.quotient = new_q;
    end

endmodule

// ==== source/srt_pipeline.sv ====
// unsigned radix-4 SRT divide pipeline, one operation per clock with fixed latency
`timescale 1ns/1ns

module srt_pipeline
    import divider_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      in_valid,
    input  word_t     dividend,
    input  word_t     divisor,
    input  sign_fix_t sign_in,
    output logic      done,
    output dword_t    result,
    output sign_fix_t sign_out
);

    srt_state_t                     norm_state;
    srt_state_t                     slot_in;
    srt_state_t [div_latency:1]     slot;
    srt_state_t [stage_count:1]     stage_out;
    srt_state_t                     last;
    logic [word_w:0]                rem_fixed;
    word_t                          quo_fixed;
    logic [4:0]                     warm_count;

    srt_normalize u_normalize (
        .dividend (dividend),
        .divisor  (divisor),
        .state    (norm_state)
    );

    always_comb begin
        slot_in       = norm_state;
        slot_in.valid = in_valid;
        slot_in.sign  = sign_in;
    end

    for (genvar i = 1; i <= stage_count; i++) begin : g_stage
        srt_stage u_stage (
            .in_state  (slot[i]),
            .out_state (stage_out[i])
        );
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            slot <= '0;
        end else begin
            slot[1]             <= slot_in;
            slot[div_latency:2] <= stage_out;
        end
    end

    // negative final remainder: add divisor back, take one off the quotient
    assign last = slot[div_latency];

    always_comb begin
        if (last.partial[2*word_w]) begin
            rem_fixed = last.partial[2*word_w:word_w] + {1'b0, last.divisor};
            quo_fixed = last.quotient - 1'b1;
        end else begin
            rem_fixed = last.partial[2*word_w:word_w];
            quo_fixed = last.quotient;
        end
    end

    assign result   = {rem_fixed[word_w-1:0] >> last.shift, quo_fixed};
    assign done     = last.valid;
    assign sign_out = last.sign;

    // cycles since reset release, saturating at the pipeline depth
    always_ff @(posedge clk) begin
        if (!resetn) begin
            warm_count <= '0;
        end else if (warm_count != div_latency) begin
            warm_count <= warm_count + 1'b1;
        end
    end

    a_done_latency: assert property (@(posedge clk) disable iff (!resetn)
        warm_count == div_latency |-> done == $past(in_valid, div_latency))
        else $error("done does not follow in_valid by the pipeline latency");

    a_rem_positive: assert property (@(posedge clk) disable iff (!resetn)
        done |-> !rem_fixed[word_w])
        else $error("corrected remainder is still negative");

endmodule

// ==== source/divider.sv ====
// top level 32-bit signed/unsigned divider returning {remainder, quotient} after a fixed latency
`timescale 1ns/1ns

module divider
    import divider_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  logic   valid,
    input  logic   is_signed,
    input  word_t  a,
    input  word_t  b,
    output dword_t hilo,
    output logic   ok
);

    word_t     a_mag;
    word_t     b_mag;
    sign_fix_t sign_tag;
    sign_fix_t sign_ret;
    dword_t    u_result;

    // magnitudes for the unsigned core
    assign a_mag = (is_signed && a[word_w-1]) ? -a : a;
    assign b_mag = (is_signed && b[word_w-1]) ? -b : b;

    assign sign_tag.neg_quotient  = is_signed && (a[word_w-1] ^ b[word_w-1]);
    assign sign_tag.neg_remainder = is_signed && a[word_w-1];

    srt_pipeline u_pipeline (
        .clk      (clk),
        .resetn   (resetn),
        .in_valid (valid),
        .dividend (a_mag),
        .divisor  (b_mag),
        .sign_in  (sign_tag),
        .done     (ok),
        .result   (u_result),
        .sign_out (sign_ret)
    );

    // remainder follows the dividend, quotient truncates toward zero
    assign hilo[2*word_w-1:word_w] = sign_ret.neg_remainder ?
                                     -u_result[2*word_w-1:word_w] : u_result[2*word_w-1:word_w];
    assign hilo[word_w-1:0]        = sign_ret.neg_quotient ?
                                     -u_result[word_w-1:0] : u_result[word_w-1:0];

    a_unsigned_tag: assert property (@(posedge clk) disable iff (!resetn)
        ok && !$past(is_signed, div_latency) |-> sign_ret == '0)
        else $error("unsigned operation came back with a sign fix");

endmodule

// ==== test/clock_gen.sv ====
// testbench clock and synchronous active-low reset source for the divider testbench
`timescale 1ns/1ns

module clock_gen #(
    parameter int period       = 8,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    // released just after an edge so the first sampled edge sees it cleanly
    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 resetn = 1'b1;
    end

endmodule

// ==== test/tb_divider.sv ====
// self-checking testbench for the pipelined SRT divider, run as the simulation top
`timescale 1ns/1ns

module tb_divider
    import divider_pkg::*;
();

    localparam int clk_period   = 8;
    localparam int reset_cycles = 4;
    localparam int idle_cycles  = 20;
    localparam int n_random     = 200;
    localparam int n_corner     = 14;
    localparam int n_mixed      = 150;
    localparam int max_gap      = 3;
    localparam int drain_slack  = 4;
    localparam int watchdog_cycles = reset_cycles + idle_cycles + 1 + 2 * n_random + n_corner
                                   + n_mixed * (max_gap + 1) + 5 * (div_latency + drain_slack)
                                   + 100;

    logic   clk;
    logic   resetn;
    logic   valid;
    logic   is_signed;
    word_t  a;
    word_t  b;
    dword_t hilo;
    logic   ok;

    logic [15:0]            lfsr_state = 16'd20681;
    dword_t                 exp_q[$];
    logic [div_latency-1:0] valid_hist = '0;
    int                     check_count = 0;
    int                     error_count = 0;
    int                     errors_at_start = 0;

    clock_gen #(
        .period       (clk_period),
        .reset_cycles (reset_cycles)
    ) u_clock (
        .clk    (clk),
        .resetn (resetn)
    );

    divider u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .is_signed (is_signed),
        .a         (a),
        .b         (b),
        .hilo      (hilo),
        .ok        (ok)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t rand_bits(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[word_w-2:0], lfsr_state[15]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // quotient truncates toward zero, remainder keeps the dividend's sign, all mod 2^32
    function automatic dword_t ref_divide(word_t av, word_t bv, logic sg);
        longint num;
        longint den;
        longint quo;
        longint rem;
        if (sg) begin
            num = longint'($signed(av));
            den = longint'($signed(bv));
        end else begin
            num = longint'(av);
            den = longint'(bv);
        end
        quo = num / den;
        rem = num % den;
        return {rem[word_w-1:0], quo[word_w-1:0]};
    endfunction

    task automatic check_dword(string name, dword_t actual, dword_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(string name, logic actual, logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // drive tasks start and end 1 ns after a rising edge
    task automatic issue(word_t av, word_t bv, logic sg);
        valid     = 1'b1;
        is_signed = sg;
        a         = av;
        b         = bv;
        exp_q.push_back(ref_divide(av, bv, sg));
        @(posedge clk);
        #1;
    endtask

    // scrambled operands while idle, the DUT must not need them held
    task automatic idle();
        valid     = 1'b0;
        is_signed = ~is_signed;
        a         = ~a;
        b         = ~b;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        valid  = 1'b0;
        while (exp_q.size() != 0 && waited < div_latency + drain_slack) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d results never came out by %0t ns", exp_q.size(), $time);
            exp_q.delete();
        end
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(string name, int ops);
        $display("%-10s %4d operations, %0d errors", name, ops, error_count - errors_at_start);
        errors_at_start = error_count;
    endtask

    task automatic run_random(logic sg);
        word_t av;
        word_t bv;
        word_t sh;
        for (int i = 0; i < n_random; i++) begin
            av = rand_bits(sg ? word_w - 1 : word_w);
            bv = rand_bits(sg ? word_w - 1 : word_w);
            sh = rand_bits(5);
            bv = bv >> sh;
            if (bv == '0) begin
                bv = 1;
            end
            // low index bits pick the four sign combinations
            if (sg && i[0]) begin
                av = -av;
            end
            if (sg && i[1]) begin
                bv = -bv;
            end
            issue(av, bv, sg);
        end
        wait_drain();
    endtask

    task automatic run_corners();
        issue(32'd123456789, 32'd1, 1'b0);
        issue(32'hffffffff, 32'd1, 1'b0);
        issue(32'd5, 32'h00010000, 1'b0);
        issue(32'hffffffff, 32'h80000001, 1'b0);
        issue(32'h7fffffff, 32'h80000000, 1'b0);
        issue(32'hc0000000, 32'h80000000, 1'b0);
        issue(32'd0, 32'd7, 1'b0);
        issue(32'd0, 32'hffffffff, 1'b1);
        issue(32'h80000000, 32'hffffffff, 1'b1);
        issue(32'h80000000, 32'd1, 1'b1);
        issue(32'h12345678, 32'h12345678, 1'b0);
        issue(32'hfffffff9, 32'hfffffff9, 1'b1);
        issue(32'hfffffff9, 32'd2, 1'b1);
        issue(32'd7, 32'hfffffffe, 1'b1);
        wait_drain();
    endtask

    task automatic run_mixed();
        word_t av;
        word_t bv;
        word_t sh;
        word_t gap;
        for (int i = 0; i < n_mixed; i++) begin
            av = rand_bits(word_w);
            bv = rand_bits(word_w);
            sh = rand_bits(5);
            bv = bv >> sh;
            if (bv == '0) begin
                bv = 1;
            end
            issue(av, bv, i[0]);
            gap = rand_bits(2);
            repeat (gap) idle();
        end
        wait_drain();
    endtask

    // outputs are stable at the falling edge
    // valid seen here is the one the DUT takes at the next rising edge
    always @(negedge clk) begin
        check_bit("ok", ok, valid_hist[div_latency-1]);
        valid_hist = {valid_hist[div_latency-2:0], valid};
        if (ok === 1'b1) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("a result came out at %0t ns with no operation pending", $time);
            end else begin
                check_dword("hilo", hilo, exp_q.pop_front());
            end
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        valid     = 1'b0;
        is_signed = 1'b0;
        a         = '0;
        b         = '0;
        wait (resetn === 1'b1);
        @(posedge clk);
        #1;

        // ok must stay quiet until the first result is due
        repeat (idle_cycles) idle();
        issue(32'd5, 32'd2, 1'b0);
        wait_drain();
        finish_test("reset", 1);

        run_random(1'b0);
        finish_test("unsigned", n_random);
        run_random(1'b1);
        finish_test("signed", n_random);
        run_corners();
        finish_test("corners", n_corner);
        run_mixed();
        finish_test("mixed", n_mixed);

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
source/divider_pkg.sv
source/srt_normalize.sv
source/srt_digit_select.sv
source/srt_stage.sv
source/srt_pipeline.sv
source/divider.sv
test/clock_gen.sv
test/tb_divider.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_divider
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
